//--- list.f
logic/xm_pkg.sv
logic/bus_event_if.sv
logic/xm_regs_if.sv
logic/bus_sync.sv
logic/vram_access.sv
logic/readback_mux.sv
logic/tenth_ms_timer.sv
logic/reg_interface.sv
test/reg_interface_props.sv
test/tb_reg_interface.sv

//--- test/tb_reg_interface.sv
`timescale 1ns/1ps

module tb_reg_interface import xm_pkg::*; ();

    logic clk, reset_i, bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    reg_num_t bus_reg_num_i;
    byte_t bus_data_i, bus_data_o;
    logic vram_sel_o, vram_wr_o, vram_ack_i;
    addr_t vram_addr_o;
    word_t vram_data_o, vram_data_i;

    word_t mem [0:65535];                           // vram model
    word_t ref_mem [0:65535];                       // expected vram contents
    integer seed = 32'h3f664974;
    int cycle_count = 0;
    int wait_cnt = 0;
    string test_name = "reset";
    logic exp_wr_q [$];                             // expected requests in order
    addr_t exp_addr_q [$];
    word_t exp_data_q [$];
    word_t m_rd_incr, m_wr_incr, m_rd_data;         // register model
    addr_t m_rd_addr, m_wr_addr;
    byte_t m_even;
    logic sel_q;

    reg_interface #(.CLK_HZ(100000)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) fail_run($sformatf("mismatch %s exp %02h got %02h", name, exp, act));
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) fail_run($sformatf("mismatch %s exp %04h got %04h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) fail_run($sformatf("mismatch %s exp %04h got %04h", name, exp, act));
    endtask

    // expected readback byte from the register model
    function automatic byte_t ref_read(input reg_num_t r, input logic bsel);
        word_t w;
        case (r)
            XM_RD_INCR:         w = m_rd_incr;
            XM_RD_ADDR:         w = m_rd_addr;
            XM_WR_INCR:         w = m_wr_incr;
            XM_WR_ADDR:         w = m_wr_addr;
            XM_DATA, XM_DATA_2: w = m_rd_data;
            default:            w = '0;
        endcase
        return bsel ? w[7:0] : w[15:8];
    endfunction

    task automatic expect_read(input addr_t a);
        exp_wr_q.push_back(1'b0);
        exp_addr_q.push_back(a);
        exp_data_q.push_back('0);
        m_rd_data = ref_mem[a];                     // completes before next access
        m_rd_addr = a + m_rd_incr;
    endtask

    task automatic model_write(input reg_num_t r, input logic bsel, input byte_t d);
        if (!bsel) begin
            case (r)
                XM_RD_INCR: m_rd_incr[15:8] = d;
                XM_RD_ADDR: m_rd_addr[15:8] = d;
                XM_WR_INCR: m_wr_incr[15:8] = d;
                XM_WR_ADDR: m_wr_addr[15:8] = d;
                XM_DATA, XM_DATA_2: m_even = d;
                default: ;
            endcase
        end else begin
            case (r)
                XM_RD_INCR: m_rd_incr[7:0] = d;
                XM_RD_ADDR: expect_read({m_rd_addr[15:8], d});
                XM_WR_INCR: m_wr_incr[7:0] = d;
                XM_WR_ADDR: m_wr_addr[7:0] = d;
                XM_DATA, XM_DATA_2: begin
                    exp_wr_q.push_back(1'b1);
                    exp_addr_q.push_back(m_wr_addr);
                    exp_data_q.push_back({m_even, d});
                    ref_mem[m_wr_addr] = {m_even, d};
                    m_wr_addr = m_wr_addr + m_wr_incr;
                end
                default: ;
            endcase
        end
    endtask

    // address setup, sample, then cs low 8 and high 8 cycles
    task automatic bus_access(input logic rd, input reg_num_t r, input logic bsel,
                              input byte_t d, output byte_t q, output int stamp);
        @(posedge clk);
        bus_rd_nwr_i  <= rd;
        bus_reg_num_i <= r;
        bus_bytesel_i <= bsel;
        bus_data_i    <= d;
        repeat (3) @(posedge clk);
        @(negedge clk);
        q = bus_data_o;                             // before any pre-read lands
        stamp = cycle_count;
        @(posedge clk);
        bus_cs_n_i <= 1'b0;
        repeat (8) @(posedge clk);
        bus_cs_n_i <= 1'b1;
        repeat (7) @(posedge clk);
    endtask

    task automatic bus_write(input reg_num_t r, input logic bsel, input byte_t d);
        byte_t q;
        int t;
        model_write(r, bsel, d);
        bus_access(1'b0, r, bsel, d, q, t);
    endtask

    task automatic bus_read(input reg_num_t r, input logic bsel, output byte_t q);
        byte_t exp;
        int t;
        exp = ref_read(r, bsel);
        if (bsel && (r == XM_DATA || r == XM_DATA_2)) expect_read(m_rd_addr);   // pre-read
        bus_access(1'b1, r, bsel, 8'h00, q, t);
        check_byte(test_name, exp, q);
    endtask

    task automatic write_word(input reg_num_t r, input word_t w);
        bus_write(r, 1'b0, w[15:8]);
        bus_write(r, 1'b1, w[7:0]);
    endtask

    task automatic read_word(input reg_num_t r, output word_t w);
        bus_read(r, 1'b0, w[15:8]);
        bus_read(r, 1'b1, w[7:0]);
    endtask

    always @(posedge clk) begin                     // vram model
        vram_ack_i <= 1'b0;
        if (reset_i) wait_cnt = 0;
        else if (vram_sel_o && !vram_ack_i) begin
            if (wait_cnt == 0) wait_cnt = 1 + ($unsigned($random(seed)) % 4);
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0) begin
                vram_ack_i  <= 1'b1;
                vram_data_i <= mem[vram_addr_o];
                if (vram_wr_o) mem[vram_addr_o] <= vram_data_o;
            end
        end
    end

    always @(posedge clk) begin                     // request compare
        sel_q <= vram_sel_o;
        if (!reset_i && vram_sel_o && !sel_q) begin
            if (exp_addr_q.size() == 0) fail_run("vram request seen that was not expected");
            check_byte({test_name, " wr"}, byte_t'(exp_wr_q.pop_front()), byte_t'(vram_wr_o));
            check_addr({test_name, " addr"}, exp_addr_q.pop_front(), vram_addr_o);
            if (vram_wr_o) check_word({test_name, " data"}, exp_data_q.pop_front(), vram_data_o);
            else void'(exp_data_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 4000) fail_run("timeout, tests did not finish in 4000 cycles");
    end

    initial begin
        reg_num_t regs [4] = '{XM_RD_INCR, XM_WR_INCR, XM_WR_ADDR, XM_RD_ADDR};
        word_t w, start;
        byte_t t1, t2;
        int c1, c2, ticks;
        reset_i = 1'b1;
        bus_cs_n_i = 1'b1;
        bus_rd_nwr_i = 1'b1;
        bus_bytesel_i = 1'b0;
        bus_reg_num_i = reg_num_t'(4'h0);
        bus_data_i = '0;
        vram_ack_i = 1'b0;
        vram_data_i = '0;
        sel_q = 1'b0;
        {m_rd_incr, m_wr_incr, m_rd_data, m_rd_addr, m_wr_addr, m_even} = '0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = word_t'(i * 16'h9e37) ^ 16'h5a3c;  // depends on every address bit
            ref_mem[i] = mem[i];
        end
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        check_byte("reset sel", 8'h00, byte_t'(vram_sel_o));
        for (int i = 2; i <= 7; i++) read_word(reg_num_t'(i), w);

        test_name = "readback";
        for (int i = 0; i < 4; i++) begin
            write_word(regs[i], word_t'($random(seed)));
            read_word(regs[i], w);
        end
        foreach (regs[i]) read_word(regs[i], w);     // nothing clobbered
        for (int i = 0; i < 3; i++) begin
            write_word(reg_num_t'(i == 2 ? 10 : i), word_t'($random(seed)));
            read_word(reg_num_t'(i == 2 ? 10 : i), w);
        end

        test_name = "vram write";
        write_word(XM_WR_INCR, word_t'($random(seed)));
        start = word_t'($random(seed));
        write_word(XM_WR_ADDR, start);
        for (int i = 0; i < 8; i++) write_word(i % 2 ? XM_DATA_2 : XM_DATA, word_t'($random(seed)));
        read_word(XM_WR_ADDR, w);
        check_addr("vram write end addr", start + 8 * m_wr_incr, w);

        test_name = "vram read";
        write_word(XM_RD_INCR, word_t'($random(seed)));
        start = word_t'($random(seed));
        write_word(XM_RD_ADDR, start);
        for (int i = 0; i < 8; i++) begin
            read_word(XM_DATA, w);
            check_word("vram read word", ref_mem[addr_t'(start + i * m_rd_incr)], w);
        end
        read_word(XM_RD_ADDR, w);
        check_addr("vram read end addr", start + 9 * m_rd_incr, w);

        test_name = "timer";
        bus_access(1'b1, XM_TIMER, 1'b1, 8'h00, t1, c1);
        repeat (200) @(posedge clk);
        bus_access(1'b1, XM_TIMER, 1'b1, 8'h00, t2, c2);
        ticks = int'(byte_t'(t2 - t1));
        if (ticks < (c2 - c1) / 10 - 2 || ticks > (c2 - c1) / 10 + 2)
            fail_run($sformatf("timer advanced %0d ticks over %0d cycles", ticks, c2 - c1));

        repeat (10) @(posedge clk);
        if (exp_addr_q.size() != 0) begin
            fail_run("expected vram requests never appeared");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

//--- test/reg_interface_props.sv
`timescale 1ns/1ps

module reg_interface_props import xm_pkg::*; (
    input logic  clk,
    input logic  reset_i,
    input logic  vram_sel_o,
    input logic  vram_wr_o,
    input addr_t vram_addr_o,
    input word_t vram_data_o,
    input logic  vram_ack_i,
    input logic  write_strobe,
    input logic  read_strobe
);

    logic waiting;                                  // request out, no ack yet

    assign waiting = vram_sel_o && !vram_ack_i;

    sel_held: assert property (@(posedge clk) disable iff (reset_i)
        waiting |=> vram_sel_o)
        else $error("vram select dropped before ack");

    req_stable: assert property (@(posedge clk) disable iff (reset_i)
        waiting |=> $stable(vram_addr_o) && $stable(vram_wr_o)
                    && (!vram_wr_o || $stable(vram_data_o)))
        else $error("vram request changed while waiting");

    one_strobe: assert property (@(posedge clk) disable iff (reset_i)
        !(write_strobe && read_strobe))
        else $error("read and write strobe together");

    sel_after_reset: assert property (@(posedge clk) reset_i |=> !vram_sel_o)
        else $error("vram select high after reset");

endmodule

bind vram_access reg_interface_props u_props (
    .clk          (clk),
    .reset_i      (reset_i),
    .vram_sel_o   (vram_sel_o),
    .vram_wr_o    (vram_wr_o),
    .vram_addr_o  (vram_addr_o),
    .vram_data_o  (vram_data_o),
    .vram_ack_i   (vram_ack_i),
    .write_strobe (ev.write_strobe),
    .read_strobe  (ev.read_strobe)
);

//--- logic/reg_interface.sv
`default_nettype none
`timescale 1ns/1ps

module reg_interface import xm_pkg::*; #(
    parameter int CLK_HZ = 100000               // passed to the timer
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     bus_cs_n_i,                // cpu select, active low
    input  logic     bus_rd_nwr_i,              // 1 read, 0 write
    input  reg_num_t bus_reg_num_i,
    input  logic     bus_bytesel_i,             // 0 even, 1 odd
    input  byte_t    bus_data_i,
    output byte_t    bus_data_o,
    output logic     vram_sel_o,
    output logic     vram_wr_o,
    output addr_t    vram_addr_o,
    output word_t    vram_data_o,
    input  word_t    vram_data_i,
    input  logic     vram_ack_i
);

    word_t timer;                               // timer to readback

    bus_event_if ev ();                         // sync to consumers
    xm_regs_if   regs ();                       // register state to readback

    bus_sync u_bus_sync (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_data_i    (bus_data_i),
        .ev            (ev.src)
    );

    vram_access u_vram_access (
        .clk         (clk),
        .reset_i     (reset_i),
        .ev          (ev.dst),
        .regs        (regs.src),
        .vram_sel_o  (vram_sel_o),
        .vram_wr_o   (vram_wr_o),
        .vram_addr_o (vram_addr_o),
        .vram_data_o (vram_data_o),
        .vram_data_i (vram_data_i),
        .vram_ack_i  (vram_ack_i)
    );

    readback_mux u_readback_mux (
        .ev         (ev.dst),
        .regs       (regs.dst),
        .timer_i    (timer),
        .bus_data_o (bus_data_o)
    );

    tenth_ms_timer #(
        .CLK_HZ (CLK_HZ)
    ) u_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .timer_o (timer)
    );

endmodule

`default_nettype wire

//--- logic/tenth_ms_timer.sv
`default_nettype none
`timescale 1ns/1ps

module tenth_ms_timer import xm_pkg::*; #(
    parameter int CLK_HZ = 100000               // clock frequency
) (
    input  logic  clk,
    input  logic  reset_i,
    output word_t timer_o                       // counts tenths of a millisecond
);

    localparam int TICK_CYCLES = CLK_HZ / 10000;                       // cycles per tick
    localparam int PRE_W       = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [PRE_W-1:0] prescale;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prescale <= '0;
            timer_o  <= '0;
        end else if (prescale == PRE_W'(TICK_CYCLES - 1)) begin
            prescale <= '0;                     // wrap
            timer_o  <= timer_o + 1'b1;         // rolls over freely
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/readback_mux.sv
`default_nettype none
`timescale 1ns/1ps

module readback_mux import xm_pkg::*; (
    bus_event_if.dst  ev,
    xm_regs_if.dst    regs,
    input  word_t     timer_i,                  // free-running timer value
    output byte_t     bus_data_o                // byte put on the bus
);

    word_t sel_word;                            // register picked by number

    always_comb begin
        case (ev.reg_num)
            XM_RD_INCR:         sel_word = regs.rd_incr;
            XM_RD_ADDR:         sel_word = regs.rd_addr;
            XM_WR_INCR:         sel_word = regs.wr_incr;
            XM_WR_ADDR:         sel_word = regs.wr_addr;
            XM_DATA, XM_DATA_2: sel_word = regs.rd_data;   // pre-read word
            XM_TIMER:           sel_word = timer_i;
            default:            sel_word = '0;             // unused numbers
        endcase
    end

    // even byte is the high half
    assign bus_data_o = ev.bytesel ? sel_word[7:0] : sel_word[15:8];

endmodule

`default_nettype wire

//--- logic/vram_access.sv
`default_nettype none
`timescale 1ns/1ps

module vram_access import xm_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    bus_event_if.dst  ev,
    xm_regs_if.src    regs,
    output logic      vram_sel_o,               // request held until ack
    output logic      vram_wr_o,                // 1 write, 0 read
    output addr_t     vram_addr_o,
    output word_t     vram_data_o,
    input  word_t     vram_data_i,              // valid with ack
    input  logic      vram_ack_i
);

    word_t rd_incr;
    addr_t rd_addr;
    word_t wr_incr;
    addr_t wr_addr;
    word_t rd_data;                             // word shown through DATA
    byte_t data_even;                           // high byte waiting for the odd write
    logic  vram_rd;                             // pending request is a read
    logic  even_wr;
    logic  odd_wr;
    logic  odd_rd;

    assign even_wr = ev.write_strobe && !ev.bytesel;
    assign odd_wr  = ev.write_strobe && ev.bytesel;   // odd byte triggers actions
    assign odd_rd  = ev.read_strobe && ev.bytesel;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
            vram_rd    <= 1'b0;
            rd_incr    <= '0;
            rd_addr    <= '0;
            wr_incr    <= '0;
            wr_addr    <= '0;
            rd_data    <= '0;
        end else begin
            if (vram_sel_o && vram_ack_i) begin
                if (vram_rd) begin
                    rd_data <= vram_data_i;             // keep word for readback
                    rd_addr <= rd_addr + rd_incr;       // post-increment
                end
                if (vram_wr_o) begin
                    wr_addr <= wr_addr + wr_incr;
                end
                vram_sel_o <= 1'b0;                     // drop select next edge
                vram_wr_o  <= 1'b0;
                vram_rd    <= 1'b0;
            end

            if (even_wr) begin
                case (ev.reg_num)
                    XM_RD_INCR: rd_incr[15:8] <= ev.data;
                    XM_RD_ADDR: rd_addr[15:8] <= ev.data;
                    XM_WR_INCR: wr_incr[15:8] <= ev.data;
                    XM_WR_ADDR: wr_addr[15:8] <= ev.data;
                    default: ;                          // DATA latch below, rest ignored
                endcase
            end

            if (odd_wr) begin
                case (ev.reg_num)
                    XM_RD_INCR: rd_incr[7:0] <= ev.data;
                    XM_RD_ADDR: begin
                        rd_addr[7:0] <= ev.data;
                        vram_addr_o  <= {rd_addr[15:8], ev.data};  // read at new address
                        vram_sel_o   <= 1'b1;
                        vram_rd      <= 1'b1;
                    end
                    XM_WR_INCR: wr_incr[7:0] <= ev.data;
                    XM_WR_ADDR: wr_addr[7:0] <= ev.data;
                    XM_DATA, XM_DATA_2: begin
                        vram_addr_o <= wr_addr;
                        vram_data_o <= {data_even, ev.data};       // even byte is high
                        vram_sel_o  <= 1'b1;
                        vram_wr_o   <= 1'b1;
                    end
                    default: ;
                endcase
            end

            // odd DATA read fetches the next word ahead of time
            if (odd_rd && (ev.reg_num == XM_DATA || ev.reg_num == XM_DATA_2)) begin
                vram_addr_o <= rd_addr;
                vram_sel_o  <= 1'b1;
                vram_rd     <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (even_wr && (ev.reg_num == XM_DATA || ev.reg_num == XM_DATA_2)) begin
            data_even <= ev.data;                       // payload, no reset
        end
    end

    assign regs.rd_incr = rd_incr;
    assign regs.rd_addr = rd_addr;
    assign regs.wr_incr = wr_incr;
    assign regs.wr_addr = wr_addr;
    assign regs.rd_data = rd_data;

endmodule

`default_nettype wire

//--- logic/bus_sync.sv
`default_nettype none
`timescale 1ns/1ps

module bus_sync import xm_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      bus_cs_n_i,               // async select, active low
    input  logic      bus_rd_nwr_i,             // 1 read, 0 write
    input  logic      bus_bytesel_i,            // 0 even byte, 1 odd byte
    input  reg_num_t  bus_reg_num_i,            // async register number
    input  byte_t     bus_data_i,               // async write data
    bus_event_if.src  ev
);

    logic [1:0] cs_n_ff;                        // [1] is the synchronised select
    logic [1:0] rd_nwr_ff;
    logic [1:0] bytesel_ff;
    reg_num_t   reg_num_meta;
    reg_num_t   reg_num_sync;
    byte_t      data_meta;
    byte_t      data_sync;
    byte_t      data_q;                         // byte held for the strobe
    logic       cs_n_last;                      // previous synchronised select
    logic       cs_fall;
    logic       write_strobe;
    logic       read_strobe;

    assign cs_fall = cs_n_last && !cs_n_ff[1];  // select first seen low

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_ff      <= 2'b11;              // bus idle
            cs_n_last    <= 1'b1;
            rd_nwr_ff    <= 2'b00;
            bytesel_ff   <= 2'b00;
            reg_num_meta <= reg_num_t'(4'h0);
            reg_num_sync <= reg_num_t'(4'h0);
            write_strobe <= 1'b0;
            read_strobe  <= 1'b0;
        end else begin
            cs_n_ff      <= {cs_n_ff[0], bus_cs_n_i};
            rd_nwr_ff    <= {rd_nwr_ff[0], bus_rd_nwr_i};
            bytesel_ff   <= {bytesel_ff[0], bus_bytesel_i};
            reg_num_meta <= bus_reg_num_i;
            reg_num_sync <= reg_num_meta;
            cs_n_last    <= cs_n_ff[1];
            write_strobe <= cs_fall && !rd_nwr_ff[1];   // one pulse per select
            read_strobe  <= cs_fall && rd_nwr_ff[1];
        end
    end

    always_ff @(posedge clk) begin
        data_meta <= bus_data_i;                // data path, no reset
        data_sync <= data_meta;
        if (cs_fall) begin
            data_q <= data_sync;                // lines up with the strobe
        end
    end

    assign ev.write_strobe = write_strobe;
    assign ev.read_strobe  = read_strobe;
    assign ev.reg_num      = reg_num_sync;      // follows the bus continuously
    assign ev.bytesel      = bytesel_ff[1];
    assign ev.data         = data_q;

endmodule

`default_nettype wire

//--- logic/xm_regs_if.sv
`default_nettype none
`timescale 1ns/1ps

interface xm_regs_if import xm_pkg::*; ();

    word_t rd_incr;                             // read increment
    addr_t rd_addr;                             // next read address
    word_t wr_incr;                             // write increment
    addr_t wr_addr;                             // next write address
    word_t rd_data;                             // last word read from vram

    modport src (output rd_incr, rd_addr, wr_incr, wr_addr, rd_data);
    modport dst (input  rd_incr, rd_addr, wr_incr, wr_addr, rd_data);

endinterface

`default_nettype wire

//--- logic/bus_event_if.sv
`default_nettype none
`timescale 1ns/1ps

interface bus_event_if import xm_pkg::*; ();

    logic     write_strobe;                     // one cycle per cpu write
    logic     read_strobe;                      // one cycle per cpu read
    reg_num_t reg_num;                          // synchronised register number
    logic     bytesel;                          // 0 even (high) byte, 1 odd (low) byte
    byte_t    data;                             // byte captured with the strobe

    modport src (output write_strobe, read_strobe, reg_num, bytesel, data);
    modport dst (input  write_strobe, read_strobe, reg_num, bytesel, data);

endinterface

`default_nettype wire

//--- logic/xm_pkg.sv
package xm_pkg;

    typedef logic [7:0]  byte_t;                // one byte on the cpu bus
    typedef logic [15:0] word_t;                // register or vram data word
    typedef logic [15:0] addr_t;                // vram word address

    // register numbers on the 4-bit bus address
    // 0, 1, 8 and 10..15 are unused and read as zero
    typedef enum logic [3:0] {
        XM_RD_INCR  = 4'h2,                     // vram read increment
        XM_RD_ADDR  = 4'h3,                     // vram read address, odd byte starts a read
        XM_WR_INCR  = 4'h4,                     // vram write increment
        XM_WR_ADDR  = 4'h5,                     // vram write address
        XM_DATA     = 4'h6,                     // vram data port
        XM_DATA_2   = 4'h7,                     // same port, second number for word moves
        XM_TIMER    = 4'h9                      // tenth-ms timer, read only
    } reg_num_t;

endpackage
